//--- sources.f
hdl/mipsPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/storeAlign.sv
hdl/loadExtend.sv
hdl/decoder.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/mipsCore.sv
testbench/mipsCore_props.sv
testbench/tbMipsCore.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tbMipsCore -f sources.f &&
{ out="$(./obj_dir/VtbMipsCore 2>&1)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -q "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tbMipsCore.sv
`timescale 1ns/100ps

module tbMipsCore;
	import mipsPkg::*;

	// program row kinds
	typedef enum logic [4:0] {
		kAddu, kSubu, kAnd, kOr, kXor, kSlt, kSll,
		kAddiu, kAndi, kOri, kLui,
		kLw, kLb, kLbu, kSw, kSb,
		kBeq, kBne, kJ
	} kindE;

	// rd is the destination for every writing kind
	typedef struct packed {
		kindE        kind;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} rowT;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} wbT;

	logic        clk = 1'b0;
	logic        arstN;
	logic [31:0] instrF;
	logic [31:0] readdataM;
	logic [31:0] pcF;
	logic [31:0] aluoutM;
	logic [31:0] writedataM;
	logic [3:0]  sigWrite;
	debugT       debugWb;

	logic [31:0] imem [256];
	logic [7:0]  dmem [256];
	rowT         prog [$];
	wbT          expQ [$];
	logic [31:0] seed;
	int          wbCount = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;

	mipsCore mipsCore_i (
		.clk       (clk),
		.arstN     (arstN),
		.instrF    (instrF),
		.readdataM (readdataM),
		.pcF       (pcF),
		.aluoutM   (aluoutM),
		.writedataM(writedataM),
		.sigWrite  (sigWrite),
		.debugWb   (debugWb)
	);

	always #50 clk = ~clk;

	// instruction read straight from pcF
	assign instrF = imem[pcF[9:2]];
	// little endian word from the data bytes
	assign readdataM = {dmem[{aluoutM[7:2], 2'd3}], dmem[{aluoutM[7:2], 2'd2}],
		dmem[{aluoutM[7:2], 2'd1}], dmem[{aluoutM[7:2], 2'd0}]};

	// fill during reset, enabled lanes written on rising edges
	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= fillByte(8'(i));
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (sigWrite[i]) begin
					dmem[{aluoutM[7:2], 2'(i)}] <= writedataM[8 * i +: 8];
				end
			end
		end
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// every address bit shapes the byte
	function automatic logic [7:0] fillByte(input logic [7:0] a);
		return a * 8'd37 + 8'h1b;
	endfunction

	// MIPS32 encodings
	function automatic logic [31:0] encode(input rowT r);
		case (r.kind)
			kAddu:  return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h21};
			kSubu:  return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h23};
			kAnd:   return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h24};
			kOr:    return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h25};
			kXor:   return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h26};
			kSlt:   return {6'h00, r.rs, r.rt, r.rd, 5'd0, 6'h2a};
			// shift amount sits in the imm column
			kSll:   return {6'h00, 5'd0, r.rt, r.rd, r.imm[4:0], 6'h00};
			kAddiu: return {6'h09, r.rs, r.rd, r.imm};
			kAndi:  return {6'h0c, r.rs, r.rd, r.imm};
			kOri:   return {6'h0d, r.rs, r.rd, r.imm};
			kLui:   return {6'h0f, 5'd0, r.rd, r.imm};
			kLw:    return {6'h23, r.rs, r.rd, r.imm};
			kLb:    return {6'h20, r.rs, r.rd, r.imm};
			kLbu:   return {6'h24, r.rs, r.rd, r.imm};
			kSw:    return {6'h2b, r.rs, r.rt, r.imm};
			kSb:    return {6'h28, r.rs, r.rt, r.imm};
			kBeq:   return {6'h04, r.rs, r.rt, r.imm};
			kBne:   return {6'h05, r.rs, r.rt, r.imm};
			// target is a word index
			kJ:     return {6'h02, 10'd0, r.imm};
			default: return 32'd0;
		endcase
	endfunction

	// rnd takes the immediate from the generator
	task automatic put(input kindE kind, input int rd, input int rs, input int rt,
		input int imm, input bit rnd);
		rowT r;
		r.kind = kind;
		r.rd = 5'(rd);
		r.rs = 5'(rs);
		r.rt = 5'(rt);
		r.imm = 16'(imm);
		if (rnd) begin
			seed = lcgNext(seed);
			r.imm = seed[31:16];
		end
		prog.push_back(r);
	endtask

	////////////////////
	// program table
	////////////////////

	task automatic loadProgram();
		// ALU chain, forwarding at distance one to three
		put(kAddiu, 1, 0, 0, 0, 1);
		put(kAddiu, 2, 0, 0, 0, 1);
		put(kAddu, 3, 1, 2, 0, 0);
		put(kSubu, 4, 3, 1, 0, 0);
		put(kAnd, 5, 3, 4, 0, 0);
		put(kOr, 6, 5, 2, 0, 0);
		put(kXor, 7, 6, 4, 0, 0);
		put(kSlt, 8, 7, 1, 0, 0);
		put(kSll, 9, 0, 3, 5, 0);
		put(kAndi, 10, 6, 0, 0, 1);
		put(kOri, 11, 7, 0, 0, 1);
		put(kLui, 12, 0, 0, 0, 1);
		// write to r0 then read it
		put(kAddiu, 0, 1, 0, 0, 1);
		put(kAddu, 13, 0, 12, 0, 0);
		// stores and loads around base 0x40
		put(kAddiu, 20, 0, 0, 16'h0040, 0);
		put(kSw, 0, 20, 3, 0, 0);
		put(kSb, 0, 20, 7, 5, 0);
		put(kLw, 14, 20, 0, 0, 0);
		put(kAddu, 15, 14, 1, 0, 0);
		put(kLb, 16, 20, 0, 5, 0);
		put(kLbu, 17, 20, 0, 5, 0);
		put(kLb, 18, 20, 0, 11, 0);
		put(kLbu, 19, 20, 0, 11, 0);
		// whole word around the stored byte, other lanes untouched
		put(kLw, 31, 20, 0, 4, 0);
		// taken beq, not taken bne
		put(kBeq, 0, 1, 1, 1, 0);
		put(kAddiu, 21, 0, 0, 1, 0);
		put(kBne, 0, 1, 1, 1, 0);
		put(kAddiu, 21, 0, 0, 2, 0);
		// branch on the result just before it
		put(kAddiu, 22, 21, 0, 3, 0);
		put(kBne, 0, 22, 21, 1, 0);
		put(kAddiu, 23, 0, 0, 7, 0);
		// branch on a load just before it
		put(kLw, 24, 20, 0, 0, 0);
		put(kBeq, 0, 24, 14, 1, 0);
		put(kAddiu, 23, 0, 0, 9, 0);
		put(kJ, 0, 0, 0, 36, 0);
		put(kAddiu, 25, 0, 0, 5, 0);
		// compare operand forwarded from memory stage
		put(kAddu, 26, 1, 2, 0, 0);
		put(kOri, 27, 0, 0, 0, 1);
		put(kBeq, 0, 26, 3, 1, 0);
		put(kAddiu, 27, 0, 0, 1, 0);
		put(kBeq, 0, 22, 21, 1, 0);
		put(kXor, 28, 26, 16, 0, 0);
		put(kSubu, 29, 28, 27, 0, 0);
		put(kSlt, 30, 29, 18, 0, 0);
	endtask

	////////////////////
	// reference model
	////////////////////

	task automatic runModel();
		logic [31:0] regs [32];
		logic [7:0]  mem [256];
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] res;
		logic [7:0]  addr;
		logic        wr;
		rowT         r;
		wbT          e;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'd0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fillByte(8'(i));
		end
		pc = resetPc;
		steps = 0;
		// one instruction per step, no delay slot
		while (((pc >> 2) < prog.size()) && (steps < 1000)) begin
			r = prog[pc >> 2];
			a = regs[r.rs];
			b = regs[r.rt];
			sx = {{16{r.imm[15]}}, r.imm};
			zx = {16'd0, r.imm};
			addr = 8'(a + sx);
			res = 32'd0;
			wr = 1'b1;
			nextPc = pc + 32'd4;
			case (r.kind)
				kAddu:  res = a + b;
				kSubu:  res = a - b;
				kAnd:   res = a & b;
				kOr:    res = a | b;
				kXor:   res = a ^ b;
				kSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				kSll:   res = b << r.imm[4:0];
				kAddiu: res = a + sx;
				kAndi:  res = a & zx;
				kOri:   res = a | zx;
				kLui:   res = {r.imm, 16'd0};
				// word port drops the low address bits
				kLw:    res = {mem[{addr[7:2], 2'd3}], mem[{addr[7:2], 2'd2}],
					mem[{addr[7:2], 2'd1}], mem[{addr[7:2], 2'd0}]};
				kLb:    res = {{24{mem[addr][7]}}, mem[addr]};
				kLbu:   res = {24'd0, mem[addr]};
				kSw: begin
					wr = 1'b0;
					for (int i = 0; i < 4; i++) begin
						mem[{addr[7:2], 2'(i)}] = b[8 * i +: 8];
					end
				end
				kSb: begin
					wr = 1'b0;
					mem[addr] = b[7:0];
				end
				kBeq: begin
					wr = 1'b0;
					if (a == b) begin
						nextPc = pc + 32'd4 + (sx << 2);
					end
				end
				kBne: begin
					wr = 1'b0;
					if (a != b) begin
						nextPc = pc + 32'd4 + (sx << 2);
					end
				end
				kJ: begin
					wr = 1'b0;
					nextPc = {nextPc[31:28], 10'd0, r.imm, 2'b00};
				end
				default: wr = 1'b0;
			endcase
			// r0 keeps zero and is never reported
			if (wr && (r.rd != 5'd0)) begin
				regs[r.rd] = res;
				e.pc = pc;
				e.wnum = r.rd;
				e.wdata = res;
				expQ.push_back(e);
			end
			pc = nextPc;
			steps++;
		end
	endtask

	////////////////////
	// checking
	////////////////////

	task automatic stopWithFail();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			stopWithFail();
		end
	endtask

	// next debug writeback against the next model entry
	task automatic checkWb();
		wbT e;
		if (debugWb.wen != 4'b0000) begin
			if (wbCount >= expQ.size()) begin
				$display("writeback to register %0d at pc %h beyond the %0d expected ones",
					debugWb.wnum, debugWb.pc, expQ.size());
				stopWithFail();
			end else begin
				e = expQ[wbCount];
				checkEq("debugWb.wen", {28'd0, debugWb.wen}, 32'h0000_000f);
				checkEq("debugWb.pc", debugWb.pc, e.pc);
				checkEq("debugWb.wnum", {27'd0, debugWb.wnum}, {27'd0, e.wnum});
				checkEq("debugWb.wdata", debugWb.wdata, e.wdata);
				wbCount++;
			end
		end
	endtask

	// about five cycles per row plus pipeline fill and reset
	always @(negedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles with %0d of %0d writebacks seen",
				cycleCount, wbCount, expQ.size());
			stopWithFail();
		end
	end

	initial begin
		arstN = 1'b0;
		seed = 32'h5626_baa4;
		loadProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'd0;
		end
		for (int i = 0; i < prog.size(); i++) begin
			imem[i] = encode(prog[i]);
		end
		cycleLimit = 5 * prog.size() + 20;
		runModel();
		// quiet ports and reset pc while held
		repeat (5) begin
			@(negedge clk);
			checkEq("sigWrite", {28'd0, sigWrite}, 32'd0);
			checkEq("debugWb.wen", {28'd0, debugWb.wen}, 32'd0);
			checkEq("pcF", pcF, resetPc);
		end
		arstN = 1'b1;
		// run until fetch leaves the program, then drain
		while (pcF < 32'(4 * prog.size())) begin
			@(negedge clk);
			checkWb();
		end
		repeat (8) begin
			@(negedge clk);
			checkWb();
		end
		if (wbCount < expQ.size()) begin
			$display("only %0d of %0d expected writebacks were seen", wbCount, expQ.size());
			stopWithFail();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

//--- testbench/mipsCore_props.sv
`timescale 1ns/100ps

module mipsCoreProps (
	input logic             clk,
	input logic             arstN,
	input mipsPkg::hazardT  haz,
	input logic [3:0]       sigWrite,
	input mipsPkg::debugT   debugWb
);

	////////////////////
	// hazard unit
	////////////////////

	// held decode leaves a bubble in E, seen two edges later in M
	stallBubbleM: assert property (@(posedge clk) disable iff (!arstN)
		$past(haz.stallD, 2) |-> (sigWrite == 4'b0000))
		else $error("stall did not leave a bubble in the memory stage");

	// same bubble one edge later in W
	stallBubbleW: assert property (@(posedge clk) disable iff (!arstN)
		$past(haz.stallD, 3) |-> (debugWb.wen == 4'b0000))
		else $error("stall did not leave a bubble in the writeback stage");

	////////////////////
	// core ports
	////////////////////

	// register 0 never shows up on the debug port
	noZeroWb: assert property (@(posedge clk) disable iff (!arstN)
		(debugWb.wen != 4'b0000) |-> (debugWb.wnum != 5'd0))
		else $error("debug writeback reported for register 0");

	// no store lanes while reset is held
	resetQuiet: assert property (@(posedge clk)
		!arstN |-> (sigWrite == 4'b0000))
		else $error("store enables active during reset");

endmodule

bind mipsCore mipsCoreProps mipsCoreProps_i (
	.clk     (clk),
	.arstN   (arstN),
	.haz     (haz),
	.sigWrite(sigWrite),
	.debugWb (debugWb)
);

//--- hdl/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
	input  logic           clk,
	input  logic           arstN,
	input  logic [31:0]    instrF,
	input  logic [31:0]    readdataM,
	output logic [31:0]    pcF,
	output logic [31:0]    aluoutM,
	output logic [31:0]    writedataM,
	output logic [3:0]     sigWrite,
	output mipsPkg::debugT debugWb
);
	import mipsPkg::*;

	// decode control
	ctrlT       ctrlD;
	branchT     brD;
	opcodeE     opD;
	logic [5:0] functD;
	// hazard loop
	hazardT     haz;
	hazardInT   hazIn;

	decoder decoder_i (
		.opD   (opD),
		.functD(functD),
		.ctrlD (ctrlD),
		.brD   (brD)
	);

	datapath datapath_i (
		.clk       (clk),
		.arstN     (arstN),
		.instrF    (instrF),
		.readdataM (readdataM),
		.ctrlD     (ctrlD),
		.brD       (brD),
		.haz       (haz),
		.pcF       (pcF),
		.aluoutM   (aluoutM),
		.writedataM(writedataM),
		.sigWrite  (sigWrite),
		.opD       (opD),
		.functD    (functD),
		.hazIn     (hazIn),
		.debugWb   (debugWb)
	);

	hazardUnit hazardUnit_i (
		.hazIn(hazIn),
		.haz  (haz)
	);

endmodule

//--- hdl/datapath.sv
`timescale 1ns/100ps

module datapath (
	input  logic              clk,
	input  logic              arstN,
	input  logic [31:0]       instrF,
	input  logic [31:0]       readdataM,
	input  mipsPkg::ctrlT     ctrlD,
	input  mipsPkg::branchT   brD,
	input  mipsPkg::hazardT   haz,
	output logic [31:0]       pcF,
	output logic [31:0]       aluoutM,
	output logic [31:0]       writedataM,
	output logic [3:0]        sigWrite,
	output mipsPkg::opcodeE   opD,
	output logic [5:0]        functD,
	output mipsPkg::hazardInT hazIn,
	output mipsPkg::debugT    debugWb
);
	import mipsPkg::*;

	// pipeline registers
	fdRegT fdQ;
	deRegT deQ;
	emRegT emQ;
	mwRegT mwQ;

	logic [31:0] pcPlus4F;
	logic [31:0] pcNextF;
	logic [4:0]  rsD;
	logic [4:0]  rtD;
	logic [4:0]  rdD;
	logic [31:0] rd1D;
	logic [31:0] rd2D;
	logic [31:0] immD;
	logic [31:0] pcPlus4D;
	logic [31:0] branchTargetD;
	logic [31:0] jumpTargetD;
	logic [31:0] cmpAD;
	logic [31:0] cmpBD;
	logic        redirectD;
	logic [31:0] srcAE;
	logic [31:0] srcBRegE;
	logic [31:0] srcBE;
	logic [31:0] aluOutE;
	logic [4:0]  writeRegE;
	logic [31:0] loadValM;
	logic [31:0] resultW;

	// execute operand mux
	function automatic logic [31:0] pickFwd(input fwdSelE sel, input logic [31:0] regVal,
		input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	////////////////////
	// fetch
	////////////////////

	assign pcPlus4F = pcF + 32'd4;
	// redirect comes from decode, no delay slot
	assign pcNextF = redirectD ? (brD.jump ? jumpTargetD : branchTargetD) : pcPlus4F;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
		end else if (!haz.stallF) begin
			pcF <= pcNextF;
		end
	end

	// flush leaves an all-zero word, a sll nop to register 0
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fdQ <= '0;
		end else if (haz.flushD) begin
			fdQ <= '0;
		end else if (!haz.stallD) begin
			fdQ.instr <= instrF;
			fdQ.pc <= pcF;
		end
	end

	////////////////////
	// decode
	////////////////////

	assign opD = opcodeE'(fdQ.instr[31:26]);
	assign functD = fdQ.instr[5:0];
	assign rsD = fdQ.instr[25:21];
	assign rtD = fdQ.instr[20:16];
	assign rdD = fdQ.instr[15:11];

	assign immD = ctrlD.zeroExt ? {16'd0, fdQ.instr[15:0]} :
		{{16{fdQ.instr[15]}}, fdQ.instr[15:0]};
	assign pcPlus4D = fdQ.pc + 32'd4;
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], fdQ.instr[25:0], 2'b00};

	regFile regFile_i (
		.clk  (clk),
		.arstN(arstN),
		.we   (mwQ.ctrl.regWrite),
		.ra1  (rsD),
		.ra2  (rtD),
		.wa   (mwQ.writeReg),
		.wd   (resultW),
		.rd1  (rd1D),
		.rd2  (rd2D)
	);

	// equality compare for beq and bne
	assign cmpAD = haz.fwdAD ? emQ.aluOut : rd1D;
	assign cmpBD = haz.fwdBD ? emQ.aluOut : rd2D;
	assign redirectD = brD.jump || (brD.branch && ((cmpAD == cmpBD) ^ brD.branchNe));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			deQ <= '0;
		end else if (haz.flushE) begin
			deQ <= '0;
		end else begin
			deQ.ctrl <= ctrlD;
			deQ.pc <= fdQ.pc;
			deQ.rd1 <= rd1D;
			deQ.rd2 <= rd2D;
			deQ.imm <= immD;
			deQ.rs <= rsD;
			deQ.rt <= rtD;
			deQ.rd <= rdD;
			deQ.shamt <= fdQ.instr[10:6];
		end
	end

	////////////////////
	// execute
	////////////////////

	assign srcAE = pickFwd(haz.fwdAE, deQ.rd1, emQ.aluOut, resultW);
	assign srcBRegE = pickFwd(haz.fwdBE, deQ.rd2, emQ.aluOut, resultW);
	assign srcBE = deQ.ctrl.aluSrc ? deQ.imm : srcBRegE;
	// rd for R-type, rt otherwise
	assign writeRegE = deQ.ctrl.regDst ? deQ.rd : deQ.rt;

	alu alu_i (
		.a    (srcAE),
		.b    (srcBE),
		.op   (deQ.ctrl.aluOp),
		.shamt(deQ.shamt),
		.y    (aluOutE)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			emQ <= '0;
		end else begin
			emQ.ctrl <= deQ.ctrl;
			emQ.pc <= deQ.pc;
			emQ.aluOut <= aluOutE;
			emQ.storeData <= srcBRegE;
			emQ.writeReg <= writeRegE;
		end
	end

	////////////////////
	// memory
	////////////////////

	assign aluoutM = emQ.aluOut;

	storeAlign storeAlign_i (
		.addr    (emQ.aluOut[1:0]),
		.size    (emQ.ctrl.memSize),
		.write   (emQ.ctrl.memWrite),
		.data    (emQ.storeData),
		.sigWrite(sigWrite),
		.dataOut (writedataM)
	);

	// read data is back in the same cycle
	loadExtend loadExtend_i (
		.addr (emQ.aluOut[1:0]),
		.size (emQ.ctrl.memSize),
		.data (readdataM),
		.value(loadValM)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mwQ <= '0;
		end else begin
			mwQ.ctrl <= emQ.ctrl;
			mwQ.pc <= emQ.pc;
			mwQ.aluOut <= emQ.aluOut;
			mwQ.loadData <= loadValM;
			mwQ.writeReg <= emQ.writeReg;
		end
	end

	////////////////////
	// writeback
	////////////////////

	assign resultW = (mwQ.ctrl.resultSrc == resLoad) ? mwQ.loadData : mwQ.aluOut;

	// writes to register 0 are not reported
	assign debugWb.pc = mwQ.pc;
	assign debugWb.wen = (mwQ.ctrl.regWrite && (mwQ.writeReg != 5'd0)) ? 4'b1111 : 4'b0000;
	assign debugWb.wnum = mwQ.writeReg;
	assign debugWb.wdata = resultW;

	// hazard unit view
	assign hazIn.rsD = rsD;
	assign hazIn.rtD = rtD;
	assign hazIn.rsE = deQ.rs;
	assign hazIn.rtE = deQ.rt;
	assign hazIn.writeRegE = writeRegE;
	assign hazIn.writeRegM = emQ.writeReg;
	assign hazIn.writeRegW = mwQ.writeReg;
	assign hazIn.regWriteE = deQ.ctrl.regWrite;
	assign hazIn.regWriteM = emQ.ctrl.regWrite;
	assign hazIn.regWriteW = mwQ.ctrl.regWrite;
	assign hazIn.memReadE = deQ.ctrl.memRead;
	assign hazIn.memReadM = emQ.ctrl.memRead;
	assign hazIn.redirectD = redirectD;
	assign hazIn.branchD = brD.branch;

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input  mipsPkg::hazardInT hazIn,
	output mipsPkg::hazardT   haz
);
	import mipsPkg::*;

	logic lwStall;
	logic brStall;
	logic stall;

	// execute operand source, memory wins over writeback
	function automatic fwdSelE fwdSrcE(input logic [4:0] src, input hazardInT h);
		if ((src != 5'd0) && h.regWriteM && (h.writeRegM == src)) begin
			return fwdMem;
		end
		if ((src != 5'd0) && h.regWriteW && (h.writeRegW == src)) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	// dst is read by the instruction in decode
	function automatic logic readByD(input logic [4:0] dst, input hazardInT h);
		return (dst != 5'd0) && ((dst == h.rsD) || (dst == h.rtD));
	endfunction

	////////////////////
	// stalls
	////////////////////

	// load in E, consumer in D
	assign lwStall = hazIn.memReadE && readByD(hazIn.writeRegE, hazIn);

	// branch compare waits for E results, and for loads still in M
	assign brStall = hazIn.branchD &&
		((hazIn.regWriteE && readByD(hazIn.writeRegE, hazIn)) ||
		(hazIn.memReadM && readByD(hazIn.writeRegM, hazIn)));

	assign stall = lwStall || brStall;

	////////////////////
	// outputs
	////////////////////

	always_comb begin
		haz.stallF = stall;
		haz.stallD = stall;
		// bubble into E while F and D hold
		haz.flushE = stall;
		// a stalled redirect may use stale operands
		haz.flushD = hazIn.redirectD && !stall;
		haz.fwdAE = fwdSrcE(hazIn.rsE, hazIn);
		haz.fwdBE = fwdSrcE(hazIn.rtE, hazIn);
		// decode compare takes M results, W comes through the bypass
		haz.fwdAD = (hazIn.rsD != 5'd0) && hazIn.regWriteM && (hazIn.writeRegM == hazIn.rsD);
		haz.fwdBD = (hazIn.rtD != 5'd0) && hazIn.regWriteM && (hazIn.writeRegM == hazIn.rtD);
	end

endmodule

//--- hdl/decoder.sv
`timescale 1ns/100ps

module decoder (
	input  mipsPkg::opcodeE opD,
	input  logic [5:0]      functD,
	output mipsPkg::ctrlT   ctrlD,
	output mipsPkg::branchT brD
);
	import mipsPkg::*;

	always_comb begin
		// unknown encodings fall out as a no-op
		ctrlD = '0;
		brD = '0;
		case (opD)
			opSpecial: begin
				ctrlD.regDst = 1'b1;
				ctrlD.regWrite = 1'b1;
				case (functD)
					fnAddu: ctrlD.aluOp = aluAdd;
					fnSubu: ctrlD.aluOp = aluSub;
					fnAnd:  ctrlD.aluOp = aluAnd;
					fnOr:   ctrlD.aluOp = aluOr;
					fnXor:  ctrlD.aluOp = aluXor;
					fnSlt:  ctrlD.aluOp = aluSlt;
					fnSll:  ctrlD.aluOp = aluSll;
					// bad funct, drop the write
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			opAddiu, opAndi, opOri, opLui: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				// logical immediates are zero extended
				ctrlD.zeroExt = (opD == opAndi) || (opD == opOri);
				case (opD)
					opAndi:  ctrlD.aluOp = aluAnd;
					opOri:   ctrlD.aluOp = aluOr;
					opLui:   ctrlD.aluOp = aluLui;
					default: ctrlD.aluOp = aluAdd;
				endcase
			end
			opLw, opLb, opLbu: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluOp = aluAdd;
				ctrlD.resultSrc = resLoad;
				ctrlD.memRead = 1'b1;
				case (opD)
					opLb:    ctrlD.memSize = memByte;
					opLbu:   ctrlD.memSize = memByteU;
					default: ctrlD.memSize = memWord;
				endcase
			end
			opSw, opSb: begin
				// address only, no register write
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluOp = aluAdd;
				ctrlD.memWrite = 1'b1;
				ctrlD.memSize = (opD == opSb) ? memByte : memWord;
			end
			opBeq: brD.branch = 1'b1;
			opBne: begin
				brD.branch = 1'b1;
				brD.branchNe = 1'b1;
			end
			opJ: brD.jump = 1'b1;
			default: begin
				ctrlD = '0;
				brD = '0;
			end
		endcase
	end

endmodule

//--- hdl/loadExtend.sv
`timescale 1ns/100ps

module loadExtend (
	input  logic [1:0]       addr,
	input  mipsPkg::memSizeE size,
	input  logic [31:0]      data,
	output logic [31:0]      value
);
	import mipsPkg::*;

	logic [7:0] byteSel;

	// little endian lane pick
	assign byteSel = data[{addr, 3'b000} +: 8];

	always_comb begin
		case (size)
			memByte:  value = {{24{byteSel[7]}}, byteSel};
			memByteU: value = {24'd0, byteSel};
			default:  value = data;
		endcase
	end

endmodule

//--- hdl/storeAlign.sv
`timescale 1ns/100ps

module storeAlign (
	input  logic [1:0]       addr,
	input  mipsPkg::memSizeE size,
	input  logic             write,
	input  logic [31:0]      data,
	output logic [3:0]       sigWrite,
	output logic [31:0]      dataOut
);
	import mipsPkg::*;

	always_comb begin
		if (size == memWord) begin
			sigWrite = 4'b1111;
			dataOut = data;
		end else begin
			// byte store, low byte on every lane
			sigWrite = 4'b0001 << addr;
			dataOut = {4{data[7:0]}};
		end
		// no lanes unless storing
		if (!write) begin
			sigWrite = 4'b0000;
		end
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic        we,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	// register 0 never takes a write
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// writeback value bypassed so decode sees it in the same cycle
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : ((we && (wa == ra1)) ? wd : regs[ra1]);
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : ((we && (wa == ra2)) ? wd : regs[ra2]);

endmodule

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	input  mipsPkg::aluOpE op,
	input  logic [4:0]     shamt,
	output logic [31:0]    y
);
	import mipsPkg::*;

	always_comb begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr:  y = a | b;
			aluXor: y = a ^ b;
			// signed compare
			aluSlt: y = {31'd0, ($signed(a) < $signed(b))};
			// shift source is rt, amount from the instruction
			aluSll: y = b << shamt;
			// immediate into the upper half
			aluLui: y = {b[15:0], 16'd0};
			default: y = 32'd0;
		endcase
	end

endmodule

//--- hdl/mipsPkg.sv
package mipsPkg;

	// fetch address after reset
	localparam logic [31:0] resetPc = 32'h0000_0000;

	// funct codes under the special opcode
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnSlt  = 6'h2a;

	////////////////////
	// encodings
	////////////////////

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLb      = 6'h20,
		opLw      = 6'h23,
		opLbu     = 6'h24,
		opSb      = 6'h28,
		opSw      = 6'h2b
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
	} aluOpE;

	typedef enum logic {resAlu, resLoad} resultSrcE;

	typedef enum logic [1:0] {memWord, memByte, memByteU} memSizeE;

	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelE;

	////////////////////
	// control and hazard bundles
	////////////////////

	typedef struct packed {
		logic      regWrite;
		logic      regDst;
		logic      aluSrc;
		logic      zeroExt;
		aluOpE     aluOp;
		resultSrcE resultSrc;
		logic      memRead;
		logic      memWrite;
		memSizeE   memSize;
	} ctrlT;

	typedef struct packed {
		logic branch;
		logic branchNe;
		logic jump;
	} branchT;

	typedef struct packed {
		logic   stallF;
		logic   stallD;
		logic   flushD;
		logic   flushE;
		fwdSelE fwdAE;
		fwdSelE fwdBE;
		// decode compare only forwards from memory
		logic   fwdAD;
		logic   fwdBD;
	} hazardT;

	typedef struct packed {
		logic [4:0] rsD;
		logic [4:0] rtD;
		logic [4:0] rsE;
		logic [4:0] rtE;
		logic [4:0] writeRegE;
		logic [4:0] writeRegM;
		logic [4:0] writeRegW;
		logic       regWriteE;
		logic       regWriteM;
		logic       regWriteW;
		logic       memReadE;
		logic       memReadM;
		logic       redirectD;
		logic       branchD;
	} hazardInT;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  wen;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} debugT;

	////////////////////
	// pipeline registers
	////////////////////

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
	} fdRegT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
	} deRegT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] storeData;
		logic [4:0]  writeReg;
	} emRegT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] loadData;
		logic [4:0]  writeReg;
	} mwRegT;

endpackage
